// File: verilog/div_types_pkg.sv
package div_types_pkg;

    // Number of lanes that are divided side by side
    localparam int lanes = 4;

    // Width of one numerator, denominator, quotient or remainder
    localparam int data_width = 32;

    // The step counter runs from data_width-1 down to zero
    localparam int cntr_width = 5;

    // Request tag, echoed back unchanged in the response
    localparam int tag_width = 4;

    // One lane word
    typedef logic [data_width-1:0] data_t;

    // All lanes of one operand or result, lane 0 in the low bits
    typedef data_t [lanes-1:0] lane_vec_t;

    // Operation codes as they appear on the bus
    // Signed forms truncate toward zero and the remainder takes the numerator's sign
    typedef enum logic [1:0] {
        op_div  = 2'd0,
        op_divu = 2'd1,
        op_rem  = 2'd2,
        op_remu = 2'd3
    } div_op_e;

    typedef logic [tag_width-1:0] tag_t;

endpackage

// File: verilog/wb_types_pkg.sv
package wb_types_pkg;

    import div_types_pkg::*;

    // Request word carried on the slave's write data
    // Field order from the top: operation, tag, numerators, denominators
    typedef struct packed {
        div_op_e   op;
        tag_t      tag;
        lane_vec_t numer;
        lane_vec_t denom;
    } wb_req_t;

    // Response word carried on the slave's read data
    // It is valid in the cycle where ack is high
    typedef struct packed {
        tag_t      tag;
        lane_vec_t result;
    } wb_rsp_t;

endpackage

// File: verilog/div_decode.sv
module div_decode
    import div_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      cyc,
    input  logic      stb,
    input  logic      we,
    input  wb_req_t   req,
    input  logic      ack,
    output logic      strobe,
    output logic      is_signed,
    output logic      want_rem,
    output tag_t      tag_q,
    output lane_vec_t numer,
    output lane_vec_t denom
);

    logic in_flight;
    logic accept;

    // A write cycle is taken only when no other request is being worked on
    assign accept = cyc && stb && we && !in_flight;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
            strobe    <= 1'b0;
        end else begin
            strobe <= accept;
            if (accept) begin
                in_flight <= 1'b1;
            end else if (ack) begin
                // The acknowledge ends the bus cycle and frees the unit
                in_flight <= 1'b0;
            end
        end
    end

    // Operands, tag and decoded flags stay put until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            numer     <= req.numer;
            denom     <= req.denom;
            tag_q     <= req.tag;
            is_signed <= (req.op == op_div) || (req.op == op_rem);
            want_rem  <= (req.op == op_rem) || (req.op == op_remu);
        end
    end

endmodule

// File: verilog/serial_div.sv
module serial_div
    import div_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      strobe,
    input  logic      is_signed,
    input  lane_vec_t numer,
    input  lane_vec_t denom,
    output logic      busy,
    output lane_vec_t quotient,
    output lane_vec_t remainder
);

    // Working register per lane holds the partial remainder above the
    // numerator bits, which are shifted out as quotient bits shift in
    logic [lanes-1:0][2*data_width:0] work_q;
    logic [lanes-1:0][data_width-1:0] divisor_q;

    // Magnitudes of the operands as seen at strobe
    lane_vec_t numer_abs;
    lane_vec_t denom_abs;

    // Trial subtraction, bit data_width set means the divisor did not fit
    logic [lanes-1:0][data_width:0] trial;

    // Sign fix-up flags, one per lane
    logic [lanes-1:0] neg_quot;
    logic [lanes-1:0] neg_rem;

    logic [cntr_width-1:0] cntr_q;
    logic busy_q;

    for (genvar i = 0; i < lanes; i++) begin : g_abs
        logic numer_neg;
        logic denom_neg;

        assign numer_neg    = is_signed && numer[i][data_width-1];
        assign denom_neg    = is_signed && denom[i][data_width-1];
        assign numer_abs[i] = numer_neg ? -numer[i] : numer[i];
        assign denom_abs[i] = denom_neg ? -denom[i] : denom[i];
        assign trial[i]     = work_q[i][2*data_width:data_width] - {1'b0, divisor_q[i]};
    end

    // Shared step counter, all lanes advance together
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_q <= 1'b0;
            cntr_q <= '0;
        end else if (strobe) begin
            busy_q <= 1'b1;
            cntr_q <= cntr_width'(data_width - 1);
        end else if (busy_q) begin
            cntr_q <= cntr_q - 1'b1;
            if (cntr_q == '0) begin
                busy_q <= 1'b0;
            end
        end
    end

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        data_t quot_raw;
        data_t rem_raw;

        always_ff @(posedge clk) begin
            if (strobe) begin
                work_q[i]    <= {{data_width{1'b0}}, numer_abs[i], 1'b0};
                divisor_q[i] <= denom_abs[i];
                // A zero divisor keeps the all-ones quotient unsigned
                neg_quot[i]  <= is_signed && (denom[i] != '0)
                                && (numer[i][data_width-1] ^ denom[i][data_width-1]);
                neg_rem[i]   <= is_signed && numer[i][data_width-1];
            end else if (busy_q) begin
                if (trial[i][data_width]) begin
                    work_q[i] <= {work_q[i][2*data_width-1:0], 1'b0};
                end else begin
                    work_q[i] <= {trial[i][data_width-1:0],
                                  work_q[i][data_width-1:0], 1'b1};
                end
            end
        end

        assign quot_raw     = work_q[i][data_width-1:0];
        assign rem_raw      = work_q[i][2*data_width:data_width+1];
        assign quotient[i]  = neg_quot[i] ? -quot_raw : quot_raw;
        assign remainder[i] = neg_rem[i] ? -rem_raw : rem_raw;
    end

    assign busy = busy_q;

endmodule

// File: verilog/div_result.sv
module div_result
    import div_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      busy,
    input  logic      want_rem,
    input  tag_t      tag_q,
    input  lane_vec_t quotient,
    input  lane_vec_t remainder,
    output logic      ack,
    output wb_rsp_t   rsp
);

    logic busy_d;
    logic done;
    lane_vec_t sel_result;

    // The divider has finished when busy drops
    assign done = busy_d && !busy;

    // Pick the requested half of the divider output for every lane
    always_comb begin
        for (int i = 0; i < lanes; i++) begin
            sel_result[i] = want_rem ? remainder[i] : quotient[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_d <= 1'b0;
            ack    <= 1'b0;
        end else begin
            busy_d <= busy;
            ack    <= done;
        end
    end

    // Response holds until the next completion so the master can sample it with ack
    always_ff @(posedge clk) begin
        if (done) begin
            rsp.tag    <= tag_q;
            rsp.result <= sel_result;
        end
    end

endmodule

// File: verilog/div_unit_top.sv
module div_unit_top
    import div_types_pkg::*;
    import wb_types_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    cyc,
    input  logic    stb,
    input  logic    we,
    input  wb_req_t req,
    output logic    ack,
    output wb_rsp_t rsp
);

    // Decode to divider and result stage
    logic      strobe;
    logic      is_signed;
    logic      want_rem;
    tag_t      tag_q;
    lane_vec_t numer;
    lane_vec_t denom;

    // Divider to result stage
    logic      busy;
    lane_vec_t quotient;
    lane_vec_t remainder;

    div_decode i_decode (
        .clk       (clk),
        .reset     (reset),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .req       (req),
        .ack       (ack),
        .strobe    (strobe),
        .is_signed (is_signed),
        .want_rem  (want_rem),
        .tag_q     (tag_q),
        .numer     (numer),
        .denom     (denom)
    );

    serial_div i_div (
        .clk       (clk),
        .reset     (reset),
        .strobe    (strobe),
        .is_signed (is_signed),
        .numer     (numer),
        .denom     (denom),
        .busy      (busy),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_result i_result (
        .clk       (clk),
        .reset     (reset),
        .busy      (busy),
        .want_rem  (want_rem),
        .tag_q     (tag_q),
        .quotient  (quotient),
        .remainder (remainder),
        .ack       (ack),
        .rsp       (rsp)
    );

endmodule

// File: testbench/div_unit_assert.sv
module div_unit_assert (
    input logic clk,
    input logic reset,
    input logic cyc,
    input logic stb,
    input logic we,
    input logic ack,
    input logic busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // Set by a write cycle the unit can take and cleared by its acknowledge
    logic pending;
    int   busy_len;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (ack) begin
            pending <= 1'b0;
        end else if (cyc && stb && we) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy_len <= 0;
        end else if (busy) begin
            busy_len <= busy_len + 1;
        end else begin
            busy_len <= 0;
        end
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset) ack |=> !ack)
        else $error("ack stayed high for more than one cycle");

    ack_after_request: assert property (@(posedge clk) disable iff (reset) ack |-> pending)
        else $error("ack without an accepted request");

    busy_length: assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> busy_len == 32)
        else $error("busy lasted %0d cycles", busy_len);

endmodule

bind div_unit_top div_unit_assert i_assert (
    .clk    (clk),
    .reset  (reset),
    .cyc    (cyc),
    .stb    (stb),
    .we     (we),
    .ack    (ack),
    .busy   (busy)
);

// File: testbench/tb_div_unit.sv
module tb_div_unit
    import div_types_pkg::*;
    import wb_types_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int reset_cycles       = 16;
    localparam int request_count      = 211;
    localparam int cycles_per_request = 200;
    localparam int ack_latency        = 35;
    localparam int watchdog_cycles    = reset_cycles + request_count * cycles_per_request;

    logic    clk;
    logic    reset;
    logic    cyc;
    logic    stb;
    logic    we;
    wb_req_t req;
    logic    ack;
    wb_rsp_t rsp;

    logic [31:0] rng_state = 32'h6fdc_8af2;

    div_unit_top i_dut (
        .clk   (clk),
        .reset (reset),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .req   (req),
        .ack   (ack),
        .rsp   (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("*** TEST FAILED ***");
        $fatal(1, "The tests did not finish within %0d clock cycles", watchdog_cycles);
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic data_t next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // Expected lane result, truncating division with the RISC-V corner cases
    function automatic data_t expected_lane(input div_op_e op, input data_t a, input data_t b);
        logic sgn;
        logic want_rem;
        int   sa;
        int   sb;
        sgn      = (op == op_div) || (op == op_rem);
        want_rem = (op == op_rem) || (op == op_remu);
        sa       = int'(a);
        sb       = int'(b);
        if (b == '0) begin
            return want_rem ? a : '1;
        end
        if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return want_rem ? '0 : a;
        end
        if (!sgn) begin
            return want_rem ? a % b : a / b;
        end
        return want_rem ? data_t'(sa % sb) : data_t'(sa / sb);
    endfunction

    function automatic lane_vec_t expected_vec(input div_op_e op, input lane_vec_t n,
                                               input lane_vec_t d);
        lane_vec_t v;
        for (int i = 0; i < lanes; i++) begin
            v[i] = expected_lane(op, n[i], d[i]);
        end
        return v;
    endfunction

    task automatic check_lanes(input string name, input lane_vec_t got, input lane_vec_t exp);
        for (int i = 0; i < lanes; i++) begin
            if (got[i] !== exp[i]) begin
                $display("[ERROR] %s lane %0d: got %h, expected %h", name, i, got[i], exp[i]);
                $display("*** TEST FAILED ***");
                $fatal(1, "Lane result mismatch");
            end
        end
    endtask

    task automatic check_tag(input string name, input tag_t got, input tag_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Tag mismatch");
        end
    endtask

    // One write cycle, stb stays high until ack is sampled
    // The latency counts edges from the accepting edge to the one that samples ack
    task automatic wb_divide(input div_op_e op, input tag_t tag, input lane_vec_t n,
                             input lane_vec_t d, input bit keep_cyc,
                             output wb_rsp_t resp, output int latency);
        wb_req_t r;
        r.op    = op;
        r.tag   = tag;
        r.numer = n;
        r.denom = d;
        @(posedge clk);
        cyc <= 1'b1;
        stb <= 1'b1;
        we  <= 1'b1;
        req <= r;
        // The unit is idle here, so this edge accepts the request
        @(posedge clk);
        latency = 0;
        do begin
            @(posedge clk);
            latency++;
        end while (!ack);
        resp = rsp;
        stb <= 1'b0;
        we  <= 1'b0;
        if (!keep_cyc) begin
            cyc <= 1'b0;
        end
    endtask

    task automatic divide_and_check(input div_op_e op, input tag_t tag, input lane_vec_t n,
                                    input lane_vec_t d);
        wb_rsp_t resp;
        int      latency;
        wb_divide(op, tag, n, d, 1'b0, resp, latency);
        check_lanes("rsp.result", resp.result, expected_vec(op, n, d));
        check_tag("rsp.tag", resp.tag, tag);
    endtask

    // Lane 3 comes first in the assignment patterns below
    task automatic test_unsigned();
        lane_vec_t n;
        lane_vec_t d;
        n = '{32'd12345678, 32'hffff_ffff, 32'd7, 32'd100};
        d = '{32'd1, 32'd16, 32'd100, 32'd7};
        divide_and_check(op_divu, 4'h3, n, d);
        divide_and_check(op_remu, 4'hc, n, d);
    endtask

    task automatic test_signed();
        lane_vec_t n;
        lane_vec_t d;
        // -7 / -2, 7 / -2, -7 / 2, 7 / 2
        n = '{32'hffff_fff9, 32'd7, 32'hffff_fff9, 32'd7};
        d = '{32'hffff_fffe, 32'hffff_fffe, 32'd2, 32'd2};
        divide_and_check(op_div, 4'h5, n, d);
        divide_and_check(op_rem, 4'ha, n, d);
    endtask

    task automatic test_div_by_zero();
        lane_vec_t n;
        lane_vec_t d;
        n = '{32'hffff_ff00, 32'd1000, 32'd0, 32'hdead_beef};
        d = '{32'd0, 32'd9, 32'd0, 32'h0000_0010};
        divide_and_check(op_div, 4'h1, n, d);
        divide_and_check(op_divu, 4'h2, n, d);
        divide_and_check(op_rem, 4'h4, n, d);
        divide_and_check(op_remu, 4'h8, n, d);
    endtask

    task automatic test_overflow();
        lane_vec_t n;
        lane_vec_t d;
        n = '{32'h8000_0000, 32'h8000_0000, 32'h8000_0000, 32'h8000_0000};
        d = '{32'd2, 32'd1, 32'hffff_ffff, 32'hffff_ffff};
        divide_and_check(op_div, 4'h6, n, d);
        divide_and_check(op_rem, 4'h9, n, d);
    endtask

    task automatic test_random();
        lane_vec_t   n;
        lane_vec_t   d;
        logic [31:0] r;
        for (int k = 0; k < 200; k++) begin
            for (int i = 0; i < lanes; i++) begin
                r    = next_random();
                n[i] = next_random();
                d[i] = next_random() >> r[7:3];
                if (r[2:0] == 3'd0) begin
                    d[i] = '0;
                end else if (r[2:0] == 3'd1) begin
                    d[i] = '1;
                end
                if (r[10:8] == 3'd0) begin
                    n[i] = 32'h8000_0000;
                end
            end
            r = next_random();
            divide_and_check(div_op_e'(r[1:0]), tag_t'(r[5:2]), n, d);
        end
    endtask

    task automatic test_ack_timing();
        lane_vec_t n;
        lane_vec_t d;
        wb_rsp_t   resp;
        int        latency;
        n = '{32'd99, 32'hffff_fff0, 32'd5, 32'd77777};
        d = '{32'd10, 32'd3, 32'd0, 32'd11};
        wb_divide(op_rem, 4'hf, n, d, 1'b1, resp, latency);
        check_lanes("rsp.result", resp.result, expected_vec(op_rem, n, d));
        check_tag("rsp.tag", resp.tag, 4'hf);
        if (latency != ack_latency) begin
            $display("Acknowledge came %0d cycles after the accepting edge instead of %0d",
                     latency, ack_latency);
            $display("*** TEST FAILED ***");
            $fatal(1, "Wrong acknowledge latency");
        end
        // cyc stays open with stb low, the unit must stay quiet
        repeat (40) begin
            @(posedge clk);
            if (ack) begin
                $display("A second acknowledge arrived while the master held the cycle open");
                $display("*** TEST FAILED ***");
                $fatal(1, "Unexpected acknowledge");
            end
        end
        cyc <= 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        req   = '0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        test_unsigned();
        test_signed();
        test_div_by_zero();
        test_overflow();
        test_random();
        test_ack_timing();
        @(posedge clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: verilog.f
verilog/div_types_pkg.sv
verilog/wb_types_pkg.sv
verilog/div_decode.sv
verilog/serial_div.sv
verilog/div_result.sv
verilog/div_unit_top.sv
testbench/div_unit_assert.sv
testbench/tb_div_unit.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the divide unit simulation with Verilator
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --timescale 1ns/1ps \
        --top-module tb_div_unit \
        -f verilog.f \
        -o sim_div_unit; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/sim_div_unit; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation finished"
exit 0
